//--- rtl/dmmu_pkg.sv
package dmmu_pkg;

   localparam int DW = 32;
   localparam int AW = 32;
   localparam int APB_AW = 12;

   // Page offset and page number widths
   localparam int PAGE_SHIFT = 13;
   localparam int VPN_W = AW - PAGE_SHIFT;
   localparam int PPN_W = DW - PAGE_SHIFT;

   // Register map
   localparam logic [APB_AW-1:0] REG_PSR = 12'h000;
   localparam logic [APB_AW-1:0] REG_DMMID = 12'h004;
   localparam logic [APB_AW-1:0] TLB_LO_BASE = 12'h400;
   localparam logic [APB_AW-1:0] TLB_HI_BASE = 12'h800;

   // Command on both bus and cache side
   typedef struct packed {
      logic [AW-1:0] addr;
      logic [2:0]    size;
      logic          we;
      logic [DW-1:0] din;
   } dbus_cmd_t;

   typedef struct packed {
      logic [VPN_W-1:0] vpn;
      logic [11:0]      reserved;
      logic             v;
   } tlb_lo_t;

   // Attribute bits s, nc and p are kept but unused
   typedef struct packed {
      logic [PPN_W-1:0] ppn;
      logic [3:0]       reserved_hi;
      logic             s;
      logic             nc;
      logic             rr;
      logic             rw;
      logic             ur;
      logic             uw;
      logic [1:0]       reserved_lo;
      logic             p;
   } tlb_hi_t;

   typedef struct packed {
      logic rm;
      logic dmme;
   } psr_t;

   typedef enum logic [1:0] {
      EXC_NONE,
      EXC_TLB_MISS,
      EXC_PAGE_FAULT
   } mmu_exc_e;

   typedef enum logic {
      APB_IDLE,
      APB_WAIT
   } apb_state_e;

endpackage

//--- rtl/dmmu_tlb_ram.sv
module dmmu_tlb_ram #(
   parameter int AW = 7,
   parameter int DW = 32
) (
   input  logic          clk,
   input  logic          rst,
   input  logic [AW-1:0] addr_a,
   input  logic          re_a,
   output logic [DW-1:0] dout_a,
   input  logic [AW-1:0] addr_b,
   input  logic          we_b,
   input  logic [DW-1:0] din_b,
   output logic [DW-1:0] dout_b
);

   logic [DW-1:0] mem [2**AW];
   logic          clr_busy;
   logic [AW-1:0] clr_idx;

   // Sweep one word per cycle after reset
   always_ff @(posedge clk) begin
      if (rst) begin
         clr_busy <= 1'b1;
         clr_idx <= '0;
      end else if (clr_busy) begin
         clr_idx <= clr_idx + 1'b1;
         if (clr_idx == '1) begin
            clr_busy <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (clr_busy) begin
         mem[clr_idx] <= '0;
      end else if (we_b) begin
         mem[addr_b] <= din_b;
      end
   end

   // Translation port, holds while not enabled
   always_ff @(posedge clk) begin
      if (re_a) begin
         dout_a <= mem[addr_a];
      end
   end

   // Register port, read-first
   always_ff @(posedge clk) begin
      dout_b <= mem[addr_b];
   end

endmodule

//--- rtl/dmmu_cmd_buf.sv
module dmmu_cmd_buf (
   input  logic clk,
   input  logic rst,
   input  logic in_valid,
   output logic in_ready,
   output logic out_valid,
   input  logic out_ready,
   input  logic cancel,
   output logic accept
);

   logic full;
   logic drain;

   // Entry leaves by transfer or by cancel
   assign drain = full & (out_ready | cancel);

   // Bypass lets a new command in while the old one leaves
   assign in_ready = ~full | drain;
   assign accept = in_valid & in_ready;
   assign out_valid = full;

   always_ff @(posedge clk) begin
      if (rst) begin
         full <= 1'b0;
      end else if (accept) begin
         full <= 1'b1;
      end else if (drain) begin
         full <= 1'b0;
      end
   end

endmodule

//--- rtl/dmmu_translate.sv
module dmmu_translate import dmmu_pkg::*; #(
   parameter int TLB_NSETS_LOG2 = 7
) (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      dbus_cmd_valid,
   output logic                      dbus_cmd_ready,
   input  dbus_cmd_t                 dbus_cmd,
   input  psr_t                      psr,
   output logic                      dcache_cmd_valid,
   input  logic                      dcache_cmd_ready,
   output dbus_cmd_t                 dcache_cmd,
   output mmu_exc_e                  exc,
   input  logic [TLB_NSETS_LOG2-1:0] tlb_lo_idx,
   input  logic                      tlb_lo_we,
   input  tlb_lo_t                   tlb_lo_wdata,
   output tlb_lo_t                   tlb_lo_rdata,
   input  logic [TLB_NSETS_LOG2-1:0] tlb_hi_idx,
   input  logic                      tlb_hi_we,
   input  tlb_hi_t                   tlb_hi_wdata,
   output tlb_hi_t                   tlb_hi_rdata
);

   logic                      accept;
   logic                      buf_valid;
   logic                      cancel;
   logic [TLB_NSETS_LOG2-1:0] rd_idx;
   dbus_cmd_t                 cmd_q;
   psr_t                      psr_q;
   tlb_lo_t                   lo_q;
   tlb_hi_t                   hi_q;
   logic                      hit;
   logic                      perm_ok;

   dmmu_cmd_buf u_cmd_buf (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (dbus_cmd_valid),
      .in_ready  (dbus_cmd_ready),
      .out_valid (buf_valid),
      .out_ready (dcache_cmd_ready),
      .cancel    (cancel),
      .accept    (accept)
   );

   // Set index from the low VPN bits
   assign rd_idx = dbus_cmd.addr[PAGE_SHIFT +: TLB_NSETS_LOG2];

   dmmu_tlb_ram #(
      .AW (TLB_NSETS_LOG2),
      .DW (DW)
   ) u_tlb_lo (
      .clk    (clk),
      .rst    (rst),
      .addr_a (rd_idx),
      .re_a   (accept),
      .dout_a (lo_q),
      .addr_b (tlb_lo_idx),
      .we_b   (tlb_lo_we),
      .din_b  (tlb_lo_wdata),
      .dout_b (tlb_lo_rdata)
   );

   dmmu_tlb_ram #(
      .AW (TLB_NSETS_LOG2),
      .DW (DW)
   ) u_tlb_hi (
      .clk    (clk),
      .rst    (rst),
      .addr_a (rd_idx),
      .re_a   (accept),
      .dout_a (hi_q),
      .addr_b (tlb_hi_idx),
      .we_b   (tlb_hi_we),
      .din_b  (tlb_hi_wdata),
      .dout_b (tlb_hi_rdata)
   );

   // Command and status sampled together with the TLB read
   always_ff @(posedge clk) begin
      if (accept) begin
         cmd_q <= dbus_cmd;
         psr_q <= psr;
      end
   end

   assign hit = lo_q.v & (lo_q.vpn == cmd_q.addr[AW-1:PAGE_SHIFT]);

   // Root mode checks rr/rw, user mode ur/uw
   always_comb begin
      if (psr_q.rm) begin
         perm_ok = cmd_q.we ? hi_q.rw : hi_q.rr;
      end else begin
         perm_ok = cmd_q.we ? hi_q.uw : hi_q.ur;
      end
   end

   always_comb begin
      exc = EXC_NONE;
      if (buf_valid && psr_q.dmme) begin
         if (!hit) begin
            exc = EXC_TLB_MISS;
         end else if (!perm_ok) begin
            exc = EXC_PAGE_FAULT;
         end
      end
   end

   // Exception drops the entry and hides it from the cache
   assign cancel = (exc != EXC_NONE);
   assign dcache_cmd_valid = buf_valid & ~cancel;

   always_comb begin
      dcache_cmd = cmd_q;
      if (psr_q.dmme) begin
         dcache_cmd.addr = {hi_q.ppn, cmd_q.addr[PAGE_SHIFT-1:0]};
      end
   end

endmodule

//--- rtl/dmmu_apb_regs.sv
module dmmu_apb_regs import dmmu_pkg::*; #(
   parameter int TLB_NSETS_LOG2 = 7
) (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      psel,
   input  logic                      penable,
   input  logic                      pwrite,
   input  logic [APB_AW-1:0]         paddr,
   input  logic [DW-1:0]             pwdata,
   output logic [DW-1:0]             prdata,
   output logic                      pready,
   output logic                      pslverr,
   output psr_t                      psr,
   output logic [TLB_NSETS_LOG2-1:0] tlb_lo_idx,
   output logic                      tlb_lo_we,
   output tlb_lo_t                   tlb_lo_wdata,
   input  tlb_lo_t                   tlb_lo_rdata,
   output logic [TLB_NSETS_LOG2-1:0] tlb_hi_idx,
   output logic                      tlb_hi_we,
   output tlb_hi_t                   tlb_hi_wdata,
   input  tlb_hi_t                   tlb_hi_rdata
);

   localparam int IDX_W = APB_AW - 4;

   apb_state_e                state;
   logic                      init_busy;
   logic [TLB_NSETS_LOG2-1:0] init_cnt;
   logic [IDX_W-1:0]          word_idx;
   logic                      go;
   logic                      sel_psr;
   logic                      sel_id;
   logic                      sel_lo;
   logic                      sel_hi;
   logic                      idx_ok;
   logic                      tlb_rd;
   logic                      err;

   // Tracks the TLB clear sweep, no access completes meanwhile
   always_ff @(posedge clk) begin
      if (rst) begin
         init_busy <= 1'b1;
         init_cnt <= '0;
      end else if (init_busy) begin
         init_cnt <= init_cnt + 1'b1;
         if (init_cnt == '1) begin
            init_busy <= 1'b0;
         end
      end
   end

   assign go = psel & penable & ~init_busy;
   assign word_idx = paddr[IDX_W+1:2];

   // Address decode
   assign sel_psr = (paddr == REG_PSR);
   assign sel_id = (paddr == REG_DMMID);
   assign sel_lo = (paddr[APB_AW-1 -: 2] == TLB_LO_BASE[APB_AW-1 -: 2]) & (paddr[1:0] == 2'b00);
   assign sel_hi = (paddr[APB_AW-1 -: 2] == TLB_HI_BASE[APB_AW-1 -: 2]) & (paddr[1:0] == 2'b00);
   assign idx_ok = ((word_idx >> TLB_NSETS_LOG2) == '0);

   assign tlb_rd = ~pwrite & (sel_lo | sel_hi) & idx_ok;
   assign err = ~(sel_psr | sel_id | ((sel_lo | sel_hi) & idx_ok)) | (sel_id & pwrite);

   // TLB reads wait one cycle for the RAM
   always_ff @(posedge clk) begin
      if (rst) begin
         state <= APB_IDLE;
      end else begin
         case (state)
            APB_IDLE: if (go && tlb_rd) state <= APB_WAIT;
            APB_WAIT: state <= APB_IDLE;
            default:  state <= APB_IDLE;
         endcase
      end
   end

   assign pready = go & ((state == APB_WAIT) | ~tlb_rd);
   assign pslverr = pready & err;

   always_ff @(posedge clk) begin
      if (rst) begin
         psr <= '0;
      end else if (go && pwrite && sel_psr) begin
         psr <= psr_t'(pwdata[1:0]);
      end
   end

   assign tlb_lo_idx = word_idx[TLB_NSETS_LOG2-1:0];
   assign tlb_hi_idx = word_idx[TLB_NSETS_LOG2-1:0];
   assign tlb_lo_we = go & pwrite & sel_lo & idx_ok;
   assign tlb_hi_we = go & pwrite & sel_hi & idx_ok;
   assign tlb_lo_wdata = tlb_lo_t'(pwdata);
   assign tlb_hi_wdata = tlb_hi_t'(pwdata);

   always_comb begin
      prdata = '0;
      if (sel_psr) begin
         prdata = DW'(psr);
      end else if (sel_id) begin
         prdata = DW'(TLB_NSETS_LOG2);
      end else if (sel_lo) begin
         prdata = tlb_lo_rdata;
      end else if (sel_hi) begin
         prdata = tlb_hi_rdata;
      end
   end

endmodule

//--- rtl/dmmu_top.sv
module dmmu_top import dmmu_pkg::*; #(
   parameter int TLB_NSETS_LOG2 = 7
) (
   input  logic              clk,
   input  logic              rst,
   // Bus side
   input  logic              dbus_cmd_valid,
   output logic              dbus_cmd_ready,
   input  dbus_cmd_t         dbus_cmd,
   output logic              dbus_valid,
   input  logic              dbus_ready,
   output logic [DW-1:0]     dbus_dout,
   // Cache side
   output logic              dcache_cmd_valid,
   input  logic              dcache_cmd_ready,
   output dbus_cmd_t         dcache_cmd,
   input  logic              dcache_valid,
   output logic              dcache_ready,
   input  logic [DW-1:0]     dcache_dout,
   output mmu_exc_e          exc,
   // Register access
   input  logic              psel,
   input  logic              penable,
   input  logic              pwrite,
   input  logic [APB_AW-1:0] paddr,
   input  logic [DW-1:0]     pwdata,
   output logic [DW-1:0]     prdata,
   output logic              pready,
   output logic              pslverr
);

   psr_t                      psr;
   logic [TLB_NSETS_LOG2-1:0] tlb_lo_idx;
   logic                      tlb_lo_we;
   tlb_lo_t                   tlb_lo_wdata;
   tlb_lo_t                   tlb_lo_rdata;
   logic [TLB_NSETS_LOG2-1:0] tlb_hi_idx;
   logic                      tlb_hi_we;
   tlb_hi_t                   tlb_hi_wdata;
   tlb_hi_t                   tlb_hi_rdata;

   // Read data goes straight back to the bus
   assign dbus_valid = dcache_valid;
   assign dcache_ready = dbus_ready;
   assign dbus_dout = dcache_dout;

   dmmu_apb_regs #(
      .TLB_NSETS_LOG2 (TLB_NSETS_LOG2)
   ) u_apb_regs (
      .clk          (clk),
      .rst          (rst),
      .psel         (psel),
      .penable      (penable),
      .pwrite       (pwrite),
      .paddr        (paddr),
      .pwdata       (pwdata),
      .prdata       (prdata),
      .pready       (pready),
      .pslverr      (pslverr),
      .psr          (psr),
      .tlb_lo_idx   (tlb_lo_idx),
      .tlb_lo_we    (tlb_lo_we),
      .tlb_lo_wdata (tlb_lo_wdata),
      .tlb_lo_rdata (tlb_lo_rdata),
      .tlb_hi_idx   (tlb_hi_idx),
      .tlb_hi_we    (tlb_hi_we),
      .tlb_hi_wdata (tlb_hi_wdata),
      .tlb_hi_rdata (tlb_hi_rdata)
   );

   dmmu_translate #(
      .TLB_NSETS_LOG2 (TLB_NSETS_LOG2)
   ) u_translate (
      .clk              (clk),
      .rst              (rst),
      .dbus_cmd_valid   (dbus_cmd_valid),
      .dbus_cmd_ready   (dbus_cmd_ready),
      .dbus_cmd         (dbus_cmd),
      .psr              (psr),
      .dcache_cmd_valid (dcache_cmd_valid),
      .dcache_cmd_ready (dcache_cmd_ready),
      .dcache_cmd       (dcache_cmd),
      .exc              (exc),
      .tlb_lo_idx       (tlb_lo_idx),
      .tlb_lo_we        (tlb_lo_we),
      .tlb_lo_wdata     (tlb_lo_wdata),
      .tlb_lo_rdata     (tlb_lo_rdata),
      .tlb_hi_idx       (tlb_hi_idx),
      .tlb_hi_we        (tlb_hi_we),
      .tlb_hi_wdata     (tlb_hi_wdata),
      .tlb_hi_rdata     (tlb_hi_rdata)
   );

endmodule

//--- verif/dmmu_assertions.sv
module dmmu_assertions import dmmu_pkg::*; (
   input logic      clk,
   input logic      rst,
   input logic      accept,
   input mmu_exc_e  exc,
   input logic      dcache_cmd_valid,
   input logic      dcache_cmd_ready,
   input dbus_cmd_t dcache_cmd
);

   // An exception belongs to the command accepted one cycle before
   assert property (@(posedge clk) disable iff (rst)
      (exc != EXC_NONE) |-> $past(accept))
      else $error("exception raised without a command accepted the cycle before");

   // Cancelled entry is dropped and never reaches the cache
   assert property (@(posedge clk) disable iff (rst)
      ((exc != EXC_NONE) && !accept) |=> ((exc == EXC_NONE) && !dcache_cmd_valid))
      else $error("exception held or cancelled command forwarded to the cache");

   // Back-pressure holds the cache command
   assert property (@(posedge clk) disable iff (rst)
      (dcache_cmd_valid && !dcache_cmd_ready) |=>
         (dcache_cmd_valid && $stable(dcache_cmd)))
      else $error("cache command changed while stalled");

endmodule

//--- verif/tb_dmmu_top.sv
module tb_dmmu_top;
   import dmmu_pkg::*;

   localparam int NSETS_LOG2 = 7;
   localparam int RESET_CYCLES = 10;
   localparam int NROWS = 11;
   localparam int NSTREAM = 8;
   localparam int MAX_CYCLES = (NROWS + 2) * 40 + RESET_CYCLES + 2**NSETS_LOG2;
   localparam logic [PPN_W-1:0] PPN = 19'h00042;
   localparam logic [AW-1:0] ADDR_A = 32'h0000_a123;
   localparam logic [AW-1:0] ADDR_B = 32'h0004_4ff8;

   logic              clk;
   logic              rst;
   logic              dbus_cmd_valid;
   logic              dbus_cmd_ready;
   dbus_cmd_t         dbus_cmd;
   logic              dbus_valid;
   logic              dbus_ready;
   logic [DW-1:0]     dbus_dout;
   logic              dcache_cmd_valid;
   logic              dcache_cmd_ready;
   dbus_cmd_t         dcache_cmd;
   logic              dcache_valid;
   logic              dcache_ready;
   logic [DW-1:0]     dcache_dout;
   mmu_exc_e          exc;
   logic              psel;
   logic              penable;
   logic              pwrite;
   logic [APB_AW-1:0] paddr;
   logic [DW-1:0]     pwdata;
   logic [DW-1:0]     prdata;
   logic              pready;
   logic              pslverr;

   int                seed;
   int                cycles;
   int                errors;
   int                test_errors;
   int                tests_run;
   int                tests_failed;

   // Stimulus table
   string             row_name [NROWS];
   logic [AW-1:0]     row_addr [NROWS];
   logic              row_we [NROWS];
   tlb_lo_t           row_lo [NROWS];
   tlb_hi_t           row_hi [NROWS];
   psr_t              row_psr [NROWS];
   mmu_exc_e          row_exc [NROWS];
   logic [AW-1:0]     row_exp_addr [NROWS];

   dmmu_top #(
      .TLB_NSETS_LOG2 (NSETS_LOG2)
   ) u_dut (
      .clk              (clk),
      .rst              (rst),
      .dbus_cmd_valid   (dbus_cmd_valid),
      .dbus_cmd_ready   (dbus_cmd_ready),
      .dbus_cmd         (dbus_cmd),
      .dbus_valid       (dbus_valid),
      .dbus_ready       (dbus_ready),
      .dbus_dout        (dbus_dout),
      .dcache_cmd_valid (dcache_cmd_valid),
      .dcache_cmd_ready (dcache_cmd_ready),
      .dcache_cmd       (dcache_cmd),
      .dcache_valid     (dcache_valid),
      .dcache_ready     (dcache_ready),
      .dcache_dout      (dcache_dout),
      .exc              (exc),
      .psel             (psel),
      .penable          (penable),
      .pwrite           (pwrite),
      .paddr            (paddr),
      .pwdata           (pwdata),
      .prdata           (prdata),
      .pready           (pready),
      .pslverr          (pslverr)
   );

   bind dmmu_translate dmmu_assertions u_assertions (
      .clk              (clk),
      .rst              (rst),
      .accept           (accept),
      .exc              (exc),
      .dcache_cmd_valid (dcache_cmd_valid),
      .dcache_cmd_ready (dcache_cmd_ready),
      .dcache_cmd       (dcache_cmd)
   );

   always #2 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("*** FAILED ***");
         $finish;
      end
   end

   function automatic tlb_lo_t make_lo(input logic [VPN_W-1:0] vpn, input logic v);
      tlb_lo_t e;
      e = '0;
      e.vpn = vpn;
      e.v = v;
      return e;
   endfunction

   // perm is {rr, rw, ur, uw}
   function automatic tlb_hi_t make_hi(input logic [PPN_W-1:0] ppn, input logic [3:0] perm);
      tlb_hi_t e;
      e = '0;
      e.ppn = ppn;
      {e.rr, e.rw, e.ur, e.uw} = perm;
      return e;
   endfunction

   function automatic logic [AW-1:0] phys_addr(input logic [PPN_W-1:0] ppn,
                                               input logic [AW-1:0] addr);
      return {ppn, addr[PAGE_SHIFT-1:0]};
   endfunction

   // Cache model read data
   function automatic logic [DW-1:0] cache_data(input logic [AW-1:0] addr);
      return {addr[15:0], ~addr[15:0]};
   endfunction

   function automatic logic [APB_AW-1:0] tlb_reg(input logic [APB_AW-1:0] base,
                                                 input logic [AW-1:0] addr);
      logic [NSETS_LOG2-1:0] idx;
      idx = addr[PAGE_SHIFT +: NSETS_LOG2];
      return base + APB_AW'({idx, 2'b00});
   endfunction

   task automatic check_exc(input string name, input mmu_exc_e exp, input mmu_exc_e act);
      if (act !== exp) begin
         errors++;
         test_errors++;
         $display("[FAIL] %s: exc expected %s, actual %s", name, exp.name(), act.name());
      end
   endtask

   task automatic check_cmd(input string name, input dbus_cmd_t exp, input dbus_cmd_t act);
      if (act !== exp) begin
         errors++;
         test_errors++;
         $display("[FAIL] %s: cache cmd expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_word(input string name, input string what,
                             input logic [DW-1:0] exp, input logic [DW-1:0] act);
      if (act !== exp) begin
         errors++;
         test_errors++;
         $display("[FAIL] %s: %s expected %h, actual %h", name, what, exp, act);
      end
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (test_errors == 0) begin
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: %0d error(s)", name, test_errors);
      end
      test_errors = 0;
   endtask

   // Sampled 1 unit after the falling edge, before the next rising edge
   task automatic apb_access(input logic write, input logic [APB_AW-1:0] addr,
                             input logic [DW-1:0] wdata, output logic [DW-1:0] rdata,
                             output logic err);
      @(negedge clk);
      psel = 1'b1;
      penable = 1'b0;
      pwrite = write;
      paddr = addr;
      pwdata = wdata;
      @(negedge clk);
      penable = 1'b1;
      #1;
      while (!pready) begin
         @(negedge clk);
         #1;
      end
      rdata = prdata;
      err = pslverr;
      @(negedge clk);
      psel = 1'b0;
      penable = 1'b0;
   endtask

   task automatic set_row(input int i, input string name, input logic [AW-1:0] addr,
                          input logic we, input tlb_lo_t lo, input tlb_hi_t hi,
                          input psr_t p, input mmu_exc_e e, input logic [AW-1:0] exp_addr);
      row_name[i] = name;
      row_addr[i] = addr;
      row_we[i] = we;
      row_lo[i] = lo;
      row_hi[i] = hi;
      row_psr[i] = p;
      row_exc[i] = e;
      row_exp_addr[i] = exp_addr;
   endtask

   task automatic run_row(input int i);
      dbus_cmd_t     cmd;
      dbus_cmd_t     exp;
      logic [DW-1:0] rd;
      logic          err;
      cmd.addr = row_addr[i];
      cmd.size = 3'd2;
      cmd.we = row_we[i];
      cmd.din = row_addr[i] ^ 32'h5a5a_5a5a;
      exp = cmd;
      exp.addr = row_exp_addr[i];
      apb_access(1'b1, tlb_reg(TLB_LO_BASE, cmd.addr), row_lo[i], rd, err);
      apb_access(1'b1, tlb_reg(TLB_HI_BASE, cmd.addr), row_hi[i], rd, err);
      apb_access(1'b1, REG_PSR, DW'(row_psr[i]), rd, err);
      @(negedge clk);
      dbus_cmd_valid = 1'b1;
      dbus_cmd = cmd;
      #1;
      while (!dbus_cmd_ready) begin
         @(negedge clk);
         #1;
      end
      @(negedge clk);
      dbus_cmd_valid = 1'b0;
      #1;
      check_exc(row_name[i], row_exc[i], exc);
      if (row_exc[i] == EXC_NONE) begin
         check_word(row_name[i], "dcache_cmd_valid", 1, DW'(dcache_cmd_valid));
         check_cmd(row_name[i], exp, dcache_cmd);
      end else begin
         check_word(row_name[i], "dcache_cmd_valid", 0, DW'(dcache_cmd_valid));
      end
      // Nothing may follow once the entry is gone
      @(negedge clk);
      #1;
      check_exc(row_name[i], EXC_NONE, exc);
      check_word(row_name[i], "dcache_cmd_valid after", 0, DW'(dcache_cmd_valid));
      finish_test(row_name[i]);
   endtask

   task automatic apb_test();
      logic [DW-1:0] rd;
      logic          err;
      apb_access(1'b1, TLB_LO_BASE + 12'h024, 32'hdead_e001, rd, err);
      apb_access(1'b0, TLB_LO_BASE + 12'h024, '0, rd, err);
      check_word("apb_regs", "tlb lo readback", 32'hdead_e001, rd);
      check_word("apb_regs", "tlb lo pslverr", 0, DW'(err));
      apb_access(1'b1, TLB_HI_BASE + 12'h024, 32'h0bad_c07f, rd, err);
      apb_access(1'b0, TLB_HI_BASE + 12'h024, '0, rd, err);
      check_word("apb_regs", "tlb hi readback", 32'h0bad_c07f, rd);
      apb_access(1'b1, REG_PSR, 32'h3, rd, err);
      apb_access(1'b0, REG_PSR, '0, rd, err);
      check_word("apb_regs", "psr readback", 32'h3, rd);
      apb_access(1'b0, REG_DMMID, '0, rd, err);
      check_word("apb_regs", "dmmid", 32'd7, rd);
      check_word("apb_regs", "dmmid pslverr", 0, DW'(err));
      apb_access(1'b0, 12'h00c, '0, rd, err);
      check_word("apb_regs", "unmapped pslverr", 1, DW'(err));
      apb_access(1'b0, TLB_LO_BASE + 12'h200, '0, rd, err);
      check_word("apb_regs", "index range pslverr", 1, DW'(err));
      apb_access(1'b1, REG_DMMID, 32'h1, rd, err);
      check_word("apb_regs", "dmmid write pslverr", 1, DW'(err));
      finish_test("apb_regs");
   endtask

   task automatic stream_test();
      dbus_cmd_t     cmds [NSTREAM];
      dbus_cmd_t     exp_q [$];
      logic [AW-1:0] last_addr;
      logic [DW-1:0] rd;
      logic          err;
      logic          resp_pending;
      int            sent;
      int            recv;
      int            rnd;
      for (int i = 0; i < NSTREAM; i++) begin
         cmds[i].addr = {VPN_W'(32'h30 + i), PAGE_SHIFT'(i * 16 + 4)};
         cmds[i].size = 3'd2;
         cmds[i].we = i[0];
         cmds[i].din = $random(seed);
         exp_q.push_back(cmds[i]);
         exp_q[i].addr = phys_addr(PPN_W'(32'h100 + i), cmds[i].addr);
         apb_access(1'b1, tlb_reg(TLB_LO_BASE, cmds[i].addr),
                    make_lo(VPN_W'(32'h30 + i), 1'b1), rd, err);
         apb_access(1'b1, tlb_reg(TLB_HI_BASE, cmds[i].addr),
                    make_hi(PPN_W'(32'h100 + i), 4'hf), rd, err);
      end
      apb_access(1'b1, REG_PSR, 32'h3, rd, err);
      sent = 0;
      recv = 0;
      resp_pending = 1'b0;
      last_addr = '0;
      while (recv < NSTREAM || resp_pending) begin
         @(negedge clk);
         rnd = $random(seed);
         dcache_cmd_ready = rnd[0];
         dbus_cmd_valid = (sent < NSTREAM);
         if (sent < NSTREAM) begin
            dbus_cmd = cmds[sent];
         end
         dcache_valid = resp_pending;
         dbus_ready = rnd[1];
         dcache_dout = cache_data(last_addr);
         #1;
         check_exc("stream", EXC_NONE, exc);
         check_word("stream", "dbus_valid", DW'(dcache_valid), DW'(dbus_valid));
         check_word("stream", "dcache_ready", DW'(dbus_ready), DW'(dcache_ready));
         if (dcache_valid) begin
            check_word("stream", "dbus_dout", cache_data(last_addr), dbus_dout);
         end
         resp_pending = 1'b0;
         if (dbus_cmd_valid && dbus_cmd_ready) begin
            sent++;
         end
         if (dcache_cmd_valid && dcache_cmd_ready) begin
            check_cmd("stream", exp_q.pop_front(), dcache_cmd);
            last_addr = dcache_cmd.addr;
            resp_pending = 1'b1;
            recv++;
         end
      end
      @(negedge clk);
      dbus_cmd_valid = 1'b0;
      dcache_valid = 1'b0;
      dcache_cmd_ready = 1'b1;
      finish_test("stream");
   endtask

   initial begin
      clk = 1'b0;
      rst = 1'b1;
      dbus_cmd_valid = 1'b0;
      dbus_cmd = '0;
      dbus_ready = 1'b0;
      dcache_cmd_ready = 1'b1;
      dcache_valid = 1'b0;
      dcache_dout = '0;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = '0;
      pwdata = '0;
      seed = 50;
      cycles = 0;
      errors = 0;
      test_errors = 0;
      tests_run = 0;
      tests_failed = 0;

      set_row(0, "off_load", 32'h1234_5678, 1'b0, make_lo('0, 1'b0), make_hi('0, 4'h0),
              2'b00, EXC_NONE, 32'h1234_5678);
      set_row(1, "off_store_any_tlb", ADDR_A, 1'b1, make_lo(19'd5, 1'b1), make_hi(PPN, 4'hf),
              2'b10, EXC_NONE, ADDR_A);
      set_row(2, "root_load", ADDR_A, 1'b0, make_lo(19'd5, 1'b1), make_hi(PPN, 4'b1000),
              2'b11, EXC_NONE, phys_addr(PPN, ADDR_A));
      set_row(3, "root_store", ADDR_B, 1'b1, make_lo(19'h22, 1'b1), make_hi(PPN, 4'b0100),
              2'b11, EXC_NONE, phys_addr(PPN, ADDR_B));
      set_row(4, "user_load", ADDR_A, 1'b0, make_lo(19'd5, 1'b1), make_hi(PPN, 4'b0010),
              2'b01, EXC_NONE, phys_addr(PPN, ADDR_A));
      set_row(5, "user_store", ADDR_B, 1'b1, make_lo(19'h22, 1'b1), make_hi(PPN, 4'b0001),
              2'b01, EXC_NONE, phys_addr(PPN, ADDR_B));
      set_row(6, "miss_invalid", ADDR_A, 1'b0, make_lo(19'd5, 1'b0), make_hi(PPN, 4'hf),
              2'b11, EXC_TLB_MISS, '0);
      set_row(7, "miss_vpn_upper", ADDR_A, 1'b0, make_lo(19'h40005, 1'b1),
              make_hi(PPN, 4'hf), 2'b01, EXC_TLB_MISS, '0);
      set_row(8, "fault_user_store", ADDR_A, 1'b1, make_lo(19'd5, 1'b1), make_hi(PPN, 4'b0010),
              2'b01, EXC_PAGE_FAULT, '0);
      set_row(9, "fault_root_load", ADDR_B, 1'b0, make_lo(19'h22, 1'b1), make_hi(PPN, 4'b0100),
              2'b11, EXC_PAGE_FAULT, '0);
      set_row(10, "miss_not_fault", ADDR_B, 1'b1, make_lo(19'h22, 1'b0), make_hi(PPN, 4'h0),
              2'b11, EXC_TLB_MISS, '0);

      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      for (int i = 0; i < NROWS; i++) begin
         run_row(i);
      end
      apb_test();
      stream_test();

      $display("Tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

//--- src.f
rtl/dmmu_pkg.sv
rtl/dmmu_tlb_ram.sv
rtl/dmmu_cmd_buf.sv
rtl/dmmu_translate.sv
rtl/dmmu_apb_regs.sv
rtl/dmmu_top.sv
verif/dmmu_assertions.sv
verif/tb_dmmu_top.sv

//--- run.sh
#!/bin/sh
# Build and run the DMMU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f \
   --top-module tb_dmmu_top -o sim_dmmu > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
   cat build.log
   echo "Build failed with status $status"
   exit 1
fi

./obj_dir/sim_dmmu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
   exit 1
fi
if ! grep -q '\*\*\* PASSED \*\*\*' sim.log; then
   echo "Simulation log has no pass result"
   exit 1
fi
exit 0
